// File: ctrl_consts.svh
// core controller constants
// widths, PC and exception-vector selector codes, forwarding selector
// codes, trap cause codes and jump-kind codes shared by the controller

`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// field widths
`define CTRL_CAUSE_W      6
`define CTRL_IRQ_ID_W     5
`define CTRL_PC_MUX_W     3
`define CTRL_EXC_PC_W     3
`define CTRL_FW_SEL_W     2
`define CTRL_JUMP_W       2
`define CTRL_REG_ADDR_W   6

// PC selector in the fetch stage
`define PC_BOOT           3'b000
`define PC_JUMP           3'b010
`define PC_BRANCH         3'b011
`define PC_EXCEPTION      3'b100
`define PC_MRET           3'b101

// exception vector selector
`define EXC_PC_EXCEPTION  3'b000
`define EXC_PC_IRQ        3'b001

// operand forwarding source
`define SEL_REGFILE       2'b00
`define SEL_FW_EX         2'b01
`define SEL_FW_WB         2'b10

// mcause codes for synchronous traps
`define CAUSE_ILLEGAL     6'h02
`define CAUSE_BREAKPOINT  6'h03
`define CAUSE_ECALL_M     6'h0B

// jump kind as reported by the decoder
`define BRANCH_NONE       2'b00
`define BRANCH_JAL        2'b01
`define BRANCH_JALR       2'b10
`define BRANCH_COND       2'b11

`endif

// File: ctrl_pkg.sv
// core controller types
// vector typedefs, the controller state encoding and the packed
// bundles passed between the FSM, hazard unit and forwarding unit

`include "ctrl_consts.svh"

package ctrl_pkg;

  // plain vectors with a meaning
  typedef logic [`CTRL_CAUSE_W-1:0]    cause_t;
  typedef logic [`CTRL_IRQ_ID_W-1:0]   irq_id_t;
  typedef logic [`CTRL_PC_MUX_W-1:0]   pc_mux_t;
  typedef logic [`CTRL_EXC_PC_W-1:0]   exc_pc_t;
  typedef logic [`CTRL_FW_SEL_W-1:0]   fw_sel_t;
  typedef logic [`CTRL_JUMP_W-1:0]     jump_kind_t;
  typedef logic [`CTRL_REG_ADDR_W-1:0] reg_addr_t;

  // controller states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    FIRST_FETCH,
    DECODE,
    IRQ_FLUSH,
    IRQ_TAKEN_ID,
    IRQ_TAKEN_IF,
    FLUSH_EX,
    FLUSH_WB,
    WAIT_SLEEP,
    SLEEP
  } ctrl_state_e;

  // decoder strobes for the instruction in ID
  typedef struct packed {
    logic       illegal;
    logic       ecall;
    logic       ebreak;
    logic       mret;
    logic       pipe_flush;
    logic       csr_status;
    jump_kind_t jump_kind;
  } dec_info_s;

  // register match bits from the ID stage comparators
  typedef struct packed {
    logic ex_is_a;
    logic ex_is_b;
    logic ex_is_c;
    logic wb_is_a;
    logic wb_is_b;
    logic wb_is_c;
    logic alu_is_a;
    logic alu_is_b;
    logic alu_is_c;
    logic we_ex;
    logic we_wb;
    logic alu_we_fw;
  } reg_match_s;

  // PC update request to the fetch stage
  typedef struct packed {
    logic    pc_set;
    pc_mux_t pc_mux;
    exc_pc_t exc_pc_mux;
  } pc_ctrl_s;

  // CSR save and restore strobes
  typedef struct packed {
    logic   save_if;
    logic   save_id;
    logic   save_ex;
    logic   save_cause;
    logic   restore_mret;
    cause_t cause;
    logic   irq_sec;
  } csr_ctrl_s;

  // forwarding selectors for operands a, b and c
  typedef struct packed {
    fw_sel_t a;
    fw_sel_t b;
    fw_sel_t c;
  } fw_sel_s;

endpackage

// File: core_ctrl_fsm.sv
// core controller FSM
// sequences boot, first fetch and decode, handles taken branches and
// unconditional jumps, pipeline flushes for traps and mret, machine
// interrupts taken from ID or IF, and the sleep handshake

`include "ctrl_consts.svh"

module core_ctrl_fsm import ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  logic      fetch_enable_i,
  input  logic      instr_valid_i,
  input  logic      id_ready_i,
  input  logic      ex_valid_i,
  input  logic      branch_taken_ex_i,
  // jump instruction still held in ID
  input  logic      jump_in_id_i,
  input  dec_info_s dec_i,

  // interrupt controller
  input  logic      irq_i,
  input  logic      irq_req_i,
  input  logic      irq_sec_i,
  input  irq_id_t   irq_id_i,
  input  logic      m_ie_i,

  input  logic      jr_stall_i,

  output logic      instr_req_o,
  output logic      ctrl_busy_o,
  output logic      is_decoding_o,
  output pc_ctrl_s  pc_ctrl_o,
  output csr_ctrl_s csr_ctrl_o,
  output cause_t    exc_cause_o,
  output logic      irq_ack_o,
  output irq_id_t   irq_id_o,
  output logic      exc_ack_o,
  output logic      exc_kill_o,
  output logic      halt_if_o,
  output logic      halt_id_o
);

  ctrl_state_e state_d;
  ctrl_state_e state_q;

  logic jump_done;
  logic jump_done_q;
  logic jump_in_dec;
  logic irq_enabled;

  // JAL and JALR target is known in ID, conditional branches resolve in EX
  assign jump_in_dec = (dec_i.jump_kind == `BRANCH_JAL) ||
                       (dec_i.jump_kind == `BRANCH_JALR);

  // only machine mode, so one enable bit gates every request
  assign irq_enabled = irq_req_i & m_ie_i;

  assign irq_id_o    = irq_id_i;

  //////////////////////////////////////////////////////////////////////
  // next state and output decode
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d       = state_q;
    jump_done     = jump_done_q;

    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;

    pc_ctrl_o.pc_set     = 1'b0;
    pc_ctrl_o.pc_mux     = `PC_BOOT;
    pc_ctrl_o.exc_pc_mux = `EXC_PC_IRQ;

    csr_ctrl_o = '0;
    exc_cause_o = '0;
    irq_ack_o   = 1'b0;
    exc_ack_o   = 1'b0;
    exc_kill_o  = 1'b0;

    unique case (state_q)
      // idle after reset, no fetch until enabled
      RESET:
      begin
        instr_req_o = 1'b0;
        if (fetch_enable_i)
        begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into the fetch stage
      BOOT_SET:
      begin
        pc_ctrl_o.pc_set = 1'b1;
        pc_ctrl_o.pc_mux = `PC_BOOT;
        state_d          = FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH:
      begin
        if (id_ready_i)
        begin
          state_d = DECODE;
        end
        // ID holds nothing yet, so the IF pc is the one saved
        if (irq_enabled)
        begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = IRQ_TAKEN_IF;
        end
      end

      DECODE:
      begin
        if (branch_taken_ex_i)
        begin
          // taken branch in EX wins, the ID instruction is squashed
          pc_ctrl_o.pc_set = 1'b1;
          pc_ctrl_o.pc_mux = `PC_BRANCH;
        end
        else if (instr_valid_i)
        begin
          is_decoding_o = 1'b1;

          if (irq_enabled)
          begin
            // drain EX before taking the interrupt
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = IRQ_FLUSH;
          end
          else
          begin
            // a masked request is dropped by the interrupt controller
            exc_kill_o = irq_req_i;

            if (jump_in_dec)
            begin
              pc_ctrl_o.pc_mux = `PC_JUMP;
              // wait out the jr stall, then redirect exactly once
              if (!jr_stall_i && !jump_done_q)
              begin
                pc_ctrl_o.pc_set = 1'b1;
                jump_done        = 1'b1;
              end
            end
            else if (dec_i.ecall || dec_i.illegal || dec_i.ebreak)
            begin
              halt_if_o             = 1'b1;
              halt_id_o             = 1'b1;
              csr_ctrl_o.save_id    = 1'b1;
              csr_ctrl_o.save_cause = 1'b1;
              if (dec_i.ecall)
                csr_ctrl_o.cause = `CAUSE_ECALL_M;
              else if (dec_i.illegal)
                csr_ctrl_o.cause = `CAUSE_ILLEGAL;
              else
                csr_ctrl_o.cause = `CAUSE_BREAKPOINT;
              state_d = FLUSH_EX;
            end
            else if (dec_i.mret)
            begin
              halt_if_o               = 1'b1;
              halt_id_o               = 1'b1;
              csr_ctrl_o.restore_mret = 1'b1;
              state_d                 = FLUSH_EX;
            end
            else if (dec_i.pipe_flush)
            begin
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
              state_d   = FLUSH_EX;
            end
            else if (dec_i.csr_status)
            begin
              // stop fetching until the CSR access has left ID
              halt_if_o = 1'b1;
              state_d   = id_ready_i ? FLUSH_EX : DECODE;
            end
          end
        end
      end

      // hold IF and ID until the EX instruction completes
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
        begin
          state_d = FLUSH_WB;
        end
      end

      // pipeline is empty, redirect for the trap or the return
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;

        if (dec_i.ecall || dec_i.illegal || dec_i.ebreak)
        begin
          pc_ctrl_o.pc_set     = 1'b1;
          pc_ctrl_o.pc_mux     = `PC_EXCEPTION;
          pc_ctrl_o.exc_pc_mux = `EXC_PC_EXCEPTION;
          if (dec_i.ecall)
            exc_cause_o = `CAUSE_ECALL_M;
          else if (dec_i.illegal)
            exc_cause_o = `CAUSE_ILLEGAL;
          else
            exc_cause_o = `CAUSE_BREAKPOINT;
        end
        else if (dec_i.mret)
        begin
          pc_ctrl_o.pc_set = 1'b1;
          pc_ctrl_o.pc_mux = `PC_MRET;
        end

        // a pipe flush here is wfi
        state_d = dec_i.pipe_flush ? WAIT_SLEEP : DECODE;
      end

      // stop fetching, busy drops once in SLEEP
      WAIT_SLEEP:
      begin
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = SLEEP;
      end

      // core clock may be gated while not busy
      SLEEP:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (irq_i)
        begin
          state_d = FIRST_FETCH;
        end
      end

      // re-check the raw line, the request may have been withdrawn
      IRQ_FLUSH:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (irq_i && m_ie_i)
        begin
          state_d = IRQ_TAKEN_ID;
        end
        else
        begin
          exc_kill_o = 1'b1;
          state_d    = DECODE;
        end
      end

      IRQ_TAKEN_ID,
      IRQ_TAKEN_IF:
      begin
        pc_ctrl_o.pc_set      = 1'b1;
        pc_ctrl_o.pc_mux      = `PC_EXCEPTION;
        pc_ctrl_o.exc_pc_mux  = `EXC_PC_IRQ;
        exc_cause_o           = {1'b0, irq_id_i};
        // interrupt bit set in mcause
        csr_ctrl_o.cause      = {1'b1, irq_id_i};
        csr_ctrl_o.irq_sec    = irq_sec_i;
        csr_ctrl_o.save_cause = 1'b1;
        csr_ctrl_o.save_id    = (state_q == IRQ_TAKEN_ID);
        csr_ctrl_o.save_if    = (state_q == IRQ_TAKEN_IF);
        irq_ack_o             = 1'b1;
        exc_ack_o             = 1'b1;
        state_d               = DECODE;
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state and jump-done registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // cleared once the jump leaves ID
      jump_done_q <= jump_done & jump_in_id_i & ~id_ready_i;
    end
  end

endmodule

// File: hazard_unit.sv
// hazard unit
// raises the load-use and jump-register stalls and decides when the
// register file write enable of the ID instruction is dropped

`include "ctrl_consts.svh"

module hazard_unit import ctrl_pkg::*;
(
  input  logic       is_decoding_i,
  input  logic       illegal_i,
  input  jump_kind_t jump_kind_i,
  input  logic       data_req_ex_i,
  input  logic       wb_ready_i,
  input  reg_match_s reg_match_i,
  input  reg_addr_t  regfile_waddr_ex_i,
  input  reg_addr_t  regfile_waddr_id_i,

  output logic       load_stall_o,
  output logic       jr_stall_o,
  output logic       deassert_we_o
);

  logic load_pending;
  logic src_hit_ex;
  logic dst_hit_id;

  // load in EX, or a WB write that has not retired yet
  assign load_pending = (data_req_ex_i & reg_match_i.we_ex) |
                        (~wb_ready_i & reg_match_i.we_wb);

  // any ID source reads the EX destination
  assign src_hit_ex = reg_match_i.ex_is_a |
                      reg_match_i.ex_is_b |
                      reg_match_i.ex_is_c;

  // write-after-write on the same destination
  assign dst_hit_id = is_decoding_i &&
                      (regfile_waddr_ex_i == regfile_waddr_id_i);

  // jalr target must come straight from the register file
  // depends only on decoder and match inputs, never on is_decoding
  assign jr_stall_o = (jump_kind_i == `BRANCH_JALR) &&
                      ((reg_match_i.we_wb     & reg_match_i.wb_is_a) ||
                       (reg_match_i.we_ex     & reg_match_i.ex_is_a) ||
                       (reg_match_i.alu_we_fw & reg_match_i.alu_is_a));

  always_comb
  begin
    load_stall_o = load_pending & (src_hit_ex | dst_hit_id);

    // no write back from a stalled, invalid or non-decoded instruction
    deassert_we_o = ~is_decoding_i | illegal_i | load_stall_o | jr_stall_o;
  end

endmodule

// File: fwd_unit.sv
// operand forwarding unit
// picks the source of operands a, b and c for the ID stage, with EX
// results taking priority over WB, and fixed overrides for misaligned
// accesses and multicycle multiplies

`include "ctrl_consts.svh"

module fwd_unit import ctrl_pkg::*;
(
  input  reg_match_s reg_match_i,
  input  logic       data_misaligned_i,
  input  logic       mult_multicycle_i,

  output fw_sel_s    fw_sel_o
);

  always_comb
  begin
    fw_sel_o.a = `SEL_REGFILE;
    fw_sel_o.b = `SEL_REGFILE;
    fw_sel_o.c = `SEL_REGFILE;

    // WB to ID
    if (reg_match_i.we_wb)
    begin
      if (reg_match_i.wb_is_a)
        fw_sel_o.a = `SEL_FW_WB;
      if (reg_match_i.wb_is_b)
        fw_sel_o.b = `SEL_FW_WB;
      if (reg_match_i.wb_is_c)
        fw_sel_o.c = `SEL_FW_WB;
    end

    // EX to ID, newer value overrides WB
    if (reg_match_i.alu_we_fw)
    begin
      if (reg_match_i.alu_is_a)
        fw_sel_o.a = `SEL_FW_EX;
      if (reg_match_i.alu_is_b)
        fw_sel_o.b = `SEL_FW_EX;
      if (reg_match_i.alu_is_c)
        fw_sel_o.c = `SEL_FW_EX;
    end

    // second half of a misaligned access reuses the EX address
    if (data_misaligned_i)
    begin
      fw_sel_o.a = `SEL_FW_EX;
      fw_sel_o.b = `SEL_REGFILE;
    end
    else if (mult_multicycle_i)
    begin
      // multiplier keeps its partial result on operand c
      fw_sel_o.c = `SEL_FW_EX;
    end
  end

endmodule

// File: core_controller.sv
// core controller top level
// connects the controller FSM, the hazard unit and the forwarding unit

module core_controller import ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       fetch_enable_i,
  input  logic       instr_valid_i,
  input  logic       id_ready_i,
  input  logic       ex_valid_i,
  input  logic       wb_ready_i,
  input  logic       branch_taken_ex_i,
  input  logic       jump_in_id_i,
  input  dec_info_s  dec_i,

  // interrupts
  input  logic       irq_i,
  input  logic       irq_req_i,
  input  logic       irq_sec_i,
  input  irq_id_t    irq_id_i,
  input  logic       m_ie_i,

  // hazard and forwarding inputs
  input  reg_match_s reg_match_i,
  input  logic       data_req_ex_i,
  input  reg_addr_t  regfile_waddr_ex_i,
  input  reg_addr_t  regfile_waddr_id_i,
  input  logic       data_misaligned_i,
  input  logic       mult_multicycle_i,

  output logic       instr_req_o,
  output logic       ctrl_busy_o,
  output logic       is_decoding_o,
  output pc_ctrl_s   pc_ctrl_o,
  output csr_ctrl_s  csr_ctrl_o,
  output cause_t     exc_cause_o,
  output logic       irq_ack_o,
  output irq_id_t    irq_id_o,
  output logic       exc_ack_o,
  output logic       exc_kill_o,
  output logic       halt_if_o,
  output logic       halt_id_o,
  output logic       deassert_we_o,
  output logic       load_stall_o,
  output logic       jr_stall_o,
  output fw_sel_s    fw_sel_o
);

  // is_decoding feeds the hazard unit, jr_stall feeds back to the FSM
  core_ctrl_fsm u_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .jump_in_id_i      (jump_in_id_i),
    .dec_i             (dec_i),
    .irq_i             (irq_i),
    .irq_req_i         (irq_req_i),
    .irq_sec_i         (irq_sec_i),
    .irq_id_i          (irq_id_i),
    .m_ie_i            (m_ie_i),
    .jr_stall_i        (jr_stall_o),
    .instr_req_o       (instr_req_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .pc_ctrl_o         (pc_ctrl_o),
    .csr_ctrl_o        (csr_ctrl_o),
    .exc_cause_o       (exc_cause_o),
    .irq_ack_o         (irq_ack_o),
    .irq_id_o          (irq_id_o),
    .exc_ack_o         (exc_ack_o),
    .exc_kill_o        (exc_kill_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  hazard_unit u_hazard (
    .is_decoding_i      (is_decoding_o),
    .illegal_i          (dec_i.illegal),
    .jump_kind_i        (dec_i.jump_kind),
    .data_req_ex_i      (data_req_ex_i),
    .wb_ready_i         (wb_ready_i),
    .reg_match_i        (reg_match_i),
    .regfile_waddr_ex_i (regfile_waddr_ex_i),
    .regfile_waddr_id_i (regfile_waddr_id_i),
    .load_stall_o       (load_stall_o),
    .jr_stall_o         (jr_stall_o),
    .deassert_we_o      (deassert_we_o)
  );

  fwd_unit u_fwd (
    .reg_match_i       (reg_match_i),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .fw_sel_o          (fw_sel_o)
  );

endmodule

// File: tb_clock_gen.sv
// testbench clock source
// free-running clock, low at time zero, toggles every half period

module tb_clock_gen #(
  parameter int period = 4
)
(
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #(period / 2) clk_o = ~clk_o;
    end
  end

endmodule

// File: core_controller_properties.sv
// core controller assertions
// pc redirect quiet in RESET, ack pairing, and IF halted in flush states

module core_controller_properties
  import ctrl_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input ctrl_state_e state_i,
  input logic        pc_set_i,
  input logic        irq_ack_i,
  input logic        exc_ack_i,
  input logic        halt_if_i
);

  // nothing may redirect fetch before boot
  assert property (@(posedge clk) disable iff (!rst_n)
                   (state_i == RESET) |-> !pc_set_i)
    else $error("pc_set high in RESET");

  // an interrupt ack is always also an exception ack
  assert property (@(posedge clk) disable iff (!rst_n)
                   irq_ack_i |-> exc_ack_i)
    else $error("irq_ack_o without exc_ack_o");

  // fetch must stay halted while the pipeline drains
  assert property (@(posedge clk) disable iff (!rst_n)
                   (state_i inside {FLUSH_EX, FLUSH_WB, IRQ_FLUSH}) |-> halt_if_i)
    else $error("halt_if_o low in a flush state");

endmodule

bind core_controller core_controller_properties u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .state_i   (u_fsm.state_q),
  .pc_set_i  (pc_ctrl_o.pc_set),
  .irq_ack_i (irq_ack_o),
  .exc_ack_i (exc_ack_o),
  .halt_if_i (halt_if_o)
);

// File: tb_core_controller.sv
// core controller testbench
// replays one cycle per line of the cases file, drives the inputs just
// after the rising edge and compares every unmasked output field just
// before the next edge

`include "ctrl_consts.svh"

module tb_core_controller
  import ctrl_pkg::*;
();

  // upper bound on replayed cycles
  localparam int max_cycles = 200;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic       fetch_enable;
  logic       instr_valid;
  logic       id_ready;
  logic       ex_valid;
  logic       wb_ready;
  logic       branch_taken;
  logic       jump_in_id;
  dec_info_s  dec;
  logic       irq;
  logic       irq_req;
  logic       irq_sec;
  irq_id_t    irq_id;
  logic       m_ie;
  reg_match_s reg_match;
  logic       data_req_ex;
  reg_addr_t  waddr_ex;
  reg_addr_t  waddr_id;
  logic       data_misaligned;
  logic       mult_multicycle;

  // DUT outputs
  logic       instr_req;
  logic       ctrl_busy;
  logic       is_decoding;
  pc_ctrl_s   pc_ctrl;
  csr_ctrl_s  csr_ctrl;
  cause_t     exc_cause;
  logic       irq_ack;
  irq_id_t    irq_id_out;
  logic       exc_ack;
  logic       exc_kill;
  logic       halt_if;
  logic       halt_id;
  logic       deassert_we;
  logic       load_stall;
  logic       jr_stall;
  fw_sel_s    fw_sel;

  // columns of the current case line
  logic [7:0]  in_ctl;
  logic [7:0]  in_dec;
  logic [3:0]  in_irq;
  logic [7:0]  in_id;
  logic [11:0] in_rm;
  logic [3:0]  in_misc;
  logic [7:0]  in_wex;
  logic [7:0]  in_wid;
  logic [7:0]  exp_flags;
  logic [3:0]  exp_haz;
  logic [7:0]  exp_pc;
  logic [11:0] exp_csr;
  logic [7:0]  exp_cause;
  logic [7:0]  exp_irq_id;
  logic [7:0]  exp_fw;
  logic [7:0]  exp_mask;

  int errors;
  int checks;
  int line_no;

  tb_clock_gen #(.period(4)) u_clk (
    .clk_o (clk)
  );

  core_controller u_core_controller (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable),
    .instr_valid_i      (instr_valid),
    .id_ready_i         (id_ready),
    .ex_valid_i         (ex_valid),
    .wb_ready_i         (wb_ready),
    .branch_taken_ex_i  (branch_taken),
    .jump_in_id_i       (jump_in_id),
    .dec_i              (dec),
    .irq_i              (irq),
    .irq_req_i          (irq_req),
    .irq_sec_i          (irq_sec),
    .irq_id_i           (irq_id),
    .m_ie_i             (m_ie),
    .reg_match_i        (reg_match),
    .data_req_ex_i      (data_req_ex),
    .regfile_waddr_ex_i (waddr_ex),
    .regfile_waddr_id_i (waddr_id),
    .data_misaligned_i  (data_misaligned),
    .mult_multicycle_i  (mult_multicycle),
    .instr_req_o        (instr_req),
    .ctrl_busy_o        (ctrl_busy),
    .is_decoding_o      (is_decoding),
    .pc_ctrl_o          (pc_ctrl),
    .csr_ctrl_o         (csr_ctrl),
    .exc_cause_o        (exc_cause),
    .irq_ack_o          (irq_ack),
    .irq_id_o           (irq_id_out),
    .exc_ack_o          (exc_ack),
    .exc_kill_o         (exc_kill),
    .halt_if_o          (halt_if),
    .halt_id_o          (halt_id),
    .deassert_we_o      (deassert_we),
    .load_stall_o       (load_stall),
    .jr_stall_o         (jr_stall),
    .fw_sel_o           (fw_sel)
  );

  //////////////////////////////////////////////////////////////////////
  // compare helpers
  //////////////////////////////////////////////////////////////////////

  task automatic compare_bit(input string name, input logic exp_v, input logic act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      errors++;
      $display("mismatch at %0t line %0d: %s expected %0h actual %0h",
               $time, line_no, name, exp_v, act_v);
    end
  endtask

  task automatic compare_field(input string name, input logic [7:0] exp_v,
                               input logic [7:0] act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      errors++;
      $display("mismatch at %0t line %0d: %s expected %0h actual %0h",
               $time, line_no, name, exp_v, act_v);
    end
  endtask

  // everything idle, used during reset
  task automatic clear_inputs;
    {fetch_enable, instr_valid, id_ready, ex_valid} = 4'b0;
    {wb_ready, branch_taken, jump_in_id} = 3'b0;
    dec = '0;
    {irq, irq_req, irq_sec, m_ie} = 4'b0;
    irq_id = '0;
    reg_match = '0;
    {data_req_ex, data_misaligned, mult_multicycle} = 3'b0;
    waddr_ex = '0;
    waddr_id = '0;
  endtask

  // unpack the input columns onto the DUT ports
  task automatic drive_case;
    {fetch_enable, instr_valid, id_ready, ex_valid, wb_ready, branch_taken,
     jump_in_id} = in_ctl[6:0];
    dec = in_dec;
    {irq, irq_req, irq_sec, m_ie} = in_irq;
    irq_id = in_id[4:0];
    reg_match = in_rm;
    {data_req_ex, data_misaligned, mult_multicycle} = in_misc[2:0];
    waddr_ex = in_wex[5:0];
    waddr_id = in_wid[5:0];
  endtask

  // one mask bit per expected column, flags in bit 6 down to fw in bit 0
  task automatic check_outputs;
    if (exp_mask[6])
    begin
      compare_bit("instr_req_o", exp_flags[7], instr_req);
      compare_bit("ctrl_busy_o", exp_flags[6], ctrl_busy);
      compare_bit("is_decoding_o", exp_flags[5], is_decoding);
      compare_bit("irq_ack_o", exp_flags[4], irq_ack);
      compare_bit("exc_ack_o", exp_flags[3], exc_ack);
      compare_bit("exc_kill_o", exp_flags[2], exc_kill);
      compare_bit("halt_if_o", exp_flags[1], halt_if);
      compare_bit("halt_id_o", exp_flags[0], halt_id);
    end
    if (exp_mask[5])
    begin
      compare_bit("deassert_we_o", exp_haz[2], deassert_we);
      compare_bit("load_stall_o", exp_haz[1], load_stall);
      compare_bit("jr_stall_o", exp_haz[0], jr_stall);
    end
    if (exp_mask[4])
    begin
      compare_bit("pc_ctrl_o.pc_set", exp_pc[6], pc_ctrl.pc_set);
      // selectors only mean something while pc_set is high
      if (exp_pc[6])
        compare_field("pc_ctrl_o.pc_mux", 8'(exp_pc[5:3]), 8'(pc_ctrl.pc_mux));
      if (exp_pc[6] && exp_pc[5:3] == `PC_EXCEPTION)
        compare_field("pc_ctrl_o.exc_pc_mux", 8'(exp_pc[2:0]), 8'(pc_ctrl.exc_pc_mux));
    end
    if (exp_mask[3])
    begin
      compare_bit("csr_ctrl_o.save_if", exp_csr[11], csr_ctrl.save_if);
      compare_bit("csr_ctrl_o.save_id", exp_csr[10], csr_ctrl.save_id);
      compare_bit("csr_ctrl_o.save_ex", exp_csr[9], csr_ctrl.save_ex);
      compare_bit("csr_ctrl_o.save_cause", exp_csr[8], csr_ctrl.save_cause);
      compare_bit("csr_ctrl_o.restore_mret", exp_csr[7], csr_ctrl.restore_mret);
      compare_field("csr_ctrl_o.cause", 8'(exp_csr[6:1]), 8'(csr_ctrl.cause));
      compare_bit("csr_ctrl_o.irq_sec", exp_csr[0], csr_ctrl.irq_sec);
    end
    if (exp_mask[2])
      compare_field("exc_cause_o", 8'(exp_cause[5:0]), 8'(exc_cause));
    if (exp_mask[1])
      compare_field("irq_id_o", 8'(exp_irq_id[4:0]), 8'(irq_id_out));
    if (exp_mask[0])
    begin
      compare_field("fw_sel_o.a", 8'(exp_fw[5:4]), 8'(fw_sel.a));
      compare_field("fw_sel_o.b", 8'(exp_fw[3:2]), 8'(fw_sel.b));
      compare_field("fw_sel_o.c", 8'(exp_fw[1:0]), 8'(fw_sel.c));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int    fd;
    int    got;
    int    fields;
    int    cycles;
    bit    timed_out;
    string line_s;

    errors    = 0;
    checks    = 0;
    line_no   = 0;
    cycles    = 0;
    timed_out = 1'b0;
    rst_n     = 1'b0;
    clear_inputs();

    // reset for 10 cycles, released just after an edge
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    fd = $fopen("core_controller_cases.txt", "r");
    if (fd == 0)
    begin
      $display("error: cannot open core_controller_cases.txt");
      errors++;
    end
    else
    begin
      while (!$feof(fd) && !timed_out)
      begin
        got = $fgets(line_s, fd);
        line_no++;
        // skip comments and blank lines
        if (got == 0 || line_s.len() < 2 || line_s[0] == "#")
          continue;
        fields = $sscanf(line_s, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         in_ctl, in_dec, in_irq, in_id, in_rm, in_misc, in_wex,
                         in_wid, exp_flags, exp_haz, exp_pc, exp_csr, exp_cause,
                         exp_irq_id, exp_fw, exp_mask);
        if (fields != 16)
        begin
          $display("error: case line %0d has %0d columns instead of 16", line_no, fields);
          errors++;
          continue;
        end
        @(posedge clk);
        #1;
        drive_case();
        // outputs settled, next edge one unit away
        #2;
        check_outputs();
        cycles++;
        if (cycles >= max_cycles && !$feof(fd))
        begin
          $display("error: timeout, %0d cycles replayed before end of cases file", cycles);
          timed_out = 1'b1;
        end
      end
      $fclose(fd);
    end

    if (cycles == 0)
    begin
      $display("error: no case line was applied");
      errors++;
    end

    $display("cases %0d, checks %0d, errors %0d", cycles, checks, errors);
    if (errors == 0 && !timed_out)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: core_controller_cases.txt
# ctl dec irq id rm mis wex wid | flags haz pc csr cause irqid fw | mask (hex, no bars)
# ctl={fe,iv,idr,exv,wbr,br,jid} irq={irq,req,sec,mie} flags={ireq,busy,dec,iack,eack,kill,hif,hid}
34 00 0 00 000 0 01 02 40 4 00 000 00 00 00 7b
74 00 0 00 000 0 01 02 40 4 00 000 00 00 00 7b
74 00 0 00 000 0 01 02 c0 4 40 000 00 00 00 7b
64 00 0 00 000 0 01 02 c0 4 00 000 00 00 00 7b
74 00 0 00 000 0 01 02 c0 4 00 000 00 00 00 7b
74 00 0 00 182 0 01 02 e0 0 00 000 00 00 28 7b
74 00 0 00 1a3 0 01 02 e0 0 00 000 00 00 18 7b
74 00 0 00 1a3 2 01 02 e0 0 00 000 00 00 10 7b
74 00 0 00 142 1 01 02 e0 0 00 000 00 00 21 7b
74 00 0 00 804 4 01 02 e0 6 00 000 00 00 00 7b
74 00 0 00 004 4 05 05 e0 6 00 000 00 00 00 7b
65 02 0 00 021 0 01 02 e0 5 00 000 00 00 10 7b
65 02 0 00 000 0 01 02 e0 0 50 000 00 00 00 7b
65 02 0 00 000 0 01 02 e0 0 00 000 00 00 00 7b
75 02 0 00 000 0 01 02 e0 0 00 000 00 00 00 7b
76 00 0 00 000 0 01 02 c0 4 58 000 00 00 00 7b
74 40 0 00 000 0 01 02 e3 0 00 516 00 00 00 7b
74 40 0 00 000 0 01 02 c3 4 00 000 00 00 00 7b
74 40 0 00 000 0 01 02 c3 4 00 000 00 00 00 7b
7c 40 0 00 000 0 01 02 c3 4 00 000 00 00 00 7b
74 40 0 00 000 0 01 02 c3 4 60 000 0b 00 00 7f
74 00 d 07 000 0 01 02 e3 0 00 000 00 07 00 7b
74 00 d 07 000 0 01 02 c3 4 00 000 00 07 00 7b
74 00 d 07 000 0 01 02 d8 4 61 54e 00 07 00 7b
74 00 1 00 000 0 01 02 e0 0 00 000 00 00 00 7b
74 00 d 03 000 0 01 02 e3 0 00 000 00 03 00 7b
74 00 1 03 000 0 01 02 c7 4 00 000 00 03 00 7b
74 00 1 00 000 0 01 02 e0 0 00 000 00 00 00 7b
74 08 1 00 000 0 01 02 e3 0 00 000 00 00 00 7b
7c 08 1 00 000 0 01 02 c3 4 00 000 00 00 00 7b
74 08 1 00 000 0 01 02 c3 4 00 000 00 00 00 7b
74 00 1 00 000 0 01 02 43 4 00 000 00 00 00 7b
74 00 1 00 000 0 01 02 03 4 00 000 00 00 00 7b
74 00 d 05 000 0 01 02 03 4 00 000 00 05 00 7b
74 00 d 05 000 0 01 02 c3 4 00 000 00 05 00 7b
74 00 f 05 000 0 01 02 d8 4 61 94b 00 05 00 7b
74 00 1 00 000 0 01 02 e0 0 00 000 00 00 00 7b
74 10 1 00 000 0 01 02 e3 0 00 080 00 00 00 7b
7c 10 1 00 000 0 01 02 c3 4 00 000 00 00 00 7b
74 10 1 00 000 0 01 02 c3 4 68 000 00 00 00 7b
74 80 1 00 000 0 01 02 e3 4 00 504 00 00 00 7b
7c 80 1 00 000 0 01 02 c3 4 00 000 00 00 00 7b
74 80 1 00 000 0 01 02 c3 4 60 000 02 00 00 7f

// File: sim.f
+incdir+.
ctrl_pkg.sv
core_ctrl_fsm.sv
hazard_unit.sv
fwd_unit.sv
core_controller.sv
tb_clock_gen.sv
core_controller_properties.sv
tb_core_controller.sv

// File: Makefile
# Verilator build and run of the core controller testbench

TOP = tb_core_controller

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "tests failed" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "all tests passed" sim.log || { echo "FAIL: no result line"; exit 1; }

clean:
	rm -rf obj_dir sim.log
